// ==== rtl/wb_types_pkg.sv ====
`default_nettype none

package wb_types_pkg;

    // Line geometry
    localparam int LINE_BEATS = 8;
    localparam int LINE_BYTES = LINE_BEATS * 4; // 32-byte aligned lines

    // Byte address of a line or of a single DMA word
    typedef logic [31:0] addr_t;

    // One beat on the eviction and memory data paths
    typedef logic [31:0] data_t;

    // Beat index within a line
    typedef logic [$clog2(LINE_BEATS)-1:0] beat_t;

endpackage

`default_nettype wire

// ==== rtl/wb_ctrl_pkg.sv ====
`default_nettype none

package wb_ctrl_pkg;

    // AXI-style burst length minus one
    typedef logic [2:0] len_t;

    localparam len_t LEN_LINE   = len_t'(7);
    localparam len_t LEN_SINGLE = len_t'(0);

    // Write sequencer states, line data phase counts beats in LINE_W
    typedef enum logic [2:0] {
        IDLE,
        DMA_AW,
        DMA_W,
        DMA_B,
        LINE_AW,
        LINE_W,
        LINE_B
    } wr_state_t;

endpackage

`default_nettype wire

// ==== rtl/wb_line_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_line_slot (
    input  logic                clk,
    input  logic                rstn,

    // Fill side
    input  logic                load_en,
    input  wb_types_pkg::beat_t load_beat,
    input  wb_types_pkg::data_t load_data,
    input  wb_types_pkg::addr_t load_addr,
    input  logic                commit,

    // Drain side
    input  logic                release_en,
    input  wb_types_pkg::beat_t rd_beat,

    output logic                slot_valid,
    output wb_types_pkg::addr_t slot_addr,
    output wb_types_pkg::data_t rd_data
);
    import wb_types_pkg::*;

    data_t words [LINE_BEATS];
    addr_t line_addr;
    logic  valid_q;

    always_ff @(posedge clk) begin
        if (load_en) begin
            words[load_beat] <= load_data;
            if (load_beat == '0)
                line_addr <= load_addr; // Address rides with the first beat
        end
    end

    // Commit and release never target the same slot in one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (commit) begin
            valid_q <= 1'b1;
        end else if (release_en) begin
            valid_q <= 1'b0;
        end
    end

    assign slot_valid = valid_q;
    assign slot_addr  = line_addr;
    assign rd_data    = words[rd_beat];

endmodule

`default_nettype wire

// ==== rtl/wb_fill.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_fill #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                       clk,
    input  logic                       rstn,

    // Eviction beats from the cache
    input  logic                       evict_valid,
    input  wb_types_pkg::addr_t        evict_addr,
    input  wb_types_pkg::data_t        evict_data,
    output logic                       evict_ready,

    // Slot status
    input  logic [NUM_SLOTS-1:0]       slot_valid,

    // Per-slot write controls, data path shared by all slots
    output logic [NUM_SLOTS-1:0]       load_en,
    output wb_types_pkg::beat_t        load_beat,
    output wb_types_pkg::data_t        load_data,
    output wb_types_pkg::addr_t        load_addr,
    output logic [NUM_SLOTS-1:0]       commit
);
    import wb_types_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);

    logic [IDX_W-1:0] tail;
    beat_t            beat_cnt;
    logic             accept;
    logic             last_beat;

    // Tail slot still holds an undrained line
    assign evict_ready = !slot_valid[tail];

    assign accept    = evict_valid && evict_ready;
    assign last_beat = (beat_cnt == beat_t'(LINE_BEATS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
            tail     <= '0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + beat_t'(1); // Wraps to 0 after beat 7
            if (last_beat)
                tail <= tail + IDX_W'(1);
        end
    end

    // Steer the accepted beat into the tail slot
    always_comb begin
        load_en = '0;
        commit  = '0;
        if (accept) begin
            load_en[tail] = 1'b1;
            commit[tail]  = last_beat; // Valid on the same edge as the last word
        end
    end

    assign load_beat = beat_cnt;
    assign load_data = evict_data;
    assign load_addr = evict_addr;

endmodule

`default_nettype wire

// ==== rtl/write_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_fsm #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                                  clk,
    input  logic                                  rstn,

    // DMA single-word request
    input  logic                                  dma_valid,
    input  wb_types_pkg::addr_t                   dma_addr,
    input  wb_types_pkg::data_t                   dma_data,
    output logic                                  dma_ready,

    // Line slots
    input  logic [NUM_SLOTS-1:0]                  slot_valid,
    input  wb_types_pkg::addr_t [NUM_SLOTS-1:0]   slot_addr,
    input  wb_types_pkg::data_t [NUM_SLOTS-1:0]   rd_data,
    output logic [NUM_SLOTS-1:0]                  release_en,
    output wb_types_pkg::beat_t                   rd_beat,

    // Memory write port
    output logic                                  aw_valid,
    input  logic                                  aw_ready,
    output wb_types_pkg::addr_t                   aw_addr,
    output wb_ctrl_pkg::len_t                     aw_len,
    output logic                                  w_valid,
    input  logic                                  w_ready,
    output wb_types_pkg::data_t                   w_data,
    output logic                                  w_last,
    input  logic                                  b_valid,
    output logic                                  b_ready
);
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);

    wr_state_t        state;
    wr_state_t        nxt;
    logic [IDX_W-1:0] head;
    beat_t            beat_cnt;
    logic             last_beat;
    logic             line_done;
    addr_t            dma_addr_q;
    data_t            dma_data_q;

    assign last_beat = (beat_cnt == beat_t'(LINE_BEATS - 1));
    assign line_done = (state == LINE_B) && b_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= IDLE;
        else
            state <= nxt;
    end

    // DMA wins over a waiting line in IDLE
    always_comb begin
        nxt = state;
        case (state)
            IDLE: begin
                if (dma_valid)
                    nxt = DMA_AW;
                else if (slot_valid[head])
                    nxt = LINE_AW;
            end
            DMA_AW:  if (aw_ready) nxt = DMA_W;
            DMA_W:   if (w_ready)  nxt = DMA_B;
            DMA_B:   if (b_valid)  nxt = IDLE;
            LINE_AW: if (aw_ready) nxt = LINE_W;
            LINE_W:  if (w_ready && last_beat) nxt = LINE_B;
            LINE_B:  if (b_valid)  nxt = IDLE;
            default: nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
            head     <= '0;
        end else begin
            if (state == LINE_W && w_ready)
                beat_cnt <= beat_cnt + beat_t'(1); // Back to 0 after the last beat
            if (line_done)
                head <= head + IDX_W'(1);
        end
    end

    // Request is taken in the dma_ready cycle
    assign dma_ready = (state == IDLE) && dma_valid;

    always_ff @(posedge clk) begin
        if (dma_ready) begin
            dma_addr_q <= dma_addr;
            dma_data_q <= dma_data;
        end
    end

    // Head slot is freed on the B handshake
    always_comb begin
        release_en = '0;
        if (line_done)
            release_en[head] = 1'b1;
    end

    assign rd_beat = beat_cnt;

    assign aw_valid = (state == DMA_AW) || (state == LINE_AW);
    assign aw_addr  = (state == DMA_AW) ? dma_addr_q : slot_addr[head];
    assign aw_len   = (state == LINE_AW) ? LEN_LINE : LEN_SINGLE;

    assign w_valid = (state == DMA_W) || (state == LINE_W);
    assign w_data  = (state == DMA_W) ? dma_data_q : rd_data[head];
    assign w_last  = (state == DMA_W) || ((state == LINE_W) && last_beat);

    assign b_ready = (state == DMA_B) || (state == LINE_B);

endmodule

`default_nettype wire

// ==== rtl/l2_write_back.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_write_back #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                clk,
    input  logic                rstn,

    // Cache eviction side
    input  logic                evict_valid,
    input  wb_types_pkg::addr_t evict_addr,
    input  wb_types_pkg::data_t evict_data,
    output logic                evict_ready,

    // DMA side
    input  logic                dma_valid,
    input  wb_types_pkg::addr_t dma_addr,
    input  wb_types_pkg::data_t dma_data,
    output logic                dma_ready,

    // Memory write port
    output logic                aw_valid,
    input  logic                aw_ready,
    output wb_types_pkg::addr_t aw_addr,
    output wb_ctrl_pkg::len_t   aw_len,
    output logic                w_valid,
    input  logic                w_ready,
    output wb_types_pkg::data_t w_data,
    output logic                w_last,
    input  logic                b_valid,
    output logic                b_ready
);
    import wb_types_pkg::*;

    logic [NUM_SLOTS-1:0]  load_en;
    beat_t                 load_beat;
    data_t                 load_data;
    addr_t                 load_addr;
    logic [NUM_SLOTS-1:0]  commit;
    logic [NUM_SLOTS-1:0]  release_en;
    beat_t                 rd_beat;
    logic [NUM_SLOTS-1:0]  slot_valid;
    addr_t [NUM_SLOTS-1:0] slot_addr;
    data_t [NUM_SLOTS-1:0] rd_data;

    wb_fill #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_fill (
        .clk         (clk),
        .rstn        (rstn),
        .evict_valid (evict_valid),
        .evict_addr  (evict_addr),
        .evict_data  (evict_data),
        .evict_ready (evict_ready),
        .slot_valid  (slot_valid),
        .load_en     (load_en),
        .load_beat   (load_beat),
        .load_data   (load_data),
        .load_addr   (load_addr),
        .commit      (commit)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        wb_line_slot u_slot (
            .clk        (clk),
            .rstn       (rstn),
            .load_en    (load_en[i]),
            .load_beat  (load_beat),
            .load_data  (load_data),
            .load_addr  (load_addr),
            .commit     (commit[i]),
            .release_en (release_en[i]),
            .rd_beat    (rd_beat),
            .slot_valid (slot_valid[i]),
            .slot_addr  (slot_addr[i]),
            .rd_data    (rd_data[i])
        );
    end

    write_fsm #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_write_fsm (
        .clk        (clk),
        .rstn       (rstn),
        .dma_valid  (dma_valid),
        .dma_addr   (dma_addr),
        .dma_data   (dma_data),
        .dma_ready  (dma_ready),
        .slot_valid (slot_valid),
        .slot_addr  (slot_addr),
        .rd_data    (rd_data),
        .release_en (release_en),
        .rd_beat    (rd_beat),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .aw_len     (aw_len),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .w_last     (w_last),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

endmodule

`default_nettype wire

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1; // Released away from the active edge
    end

endmodule

`default_nettype wire

// ==== tests/write_fsm_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_fsm_props (
    input logic                    clk,
    input logic                    rstn,
    input logic                    aw_valid,
    input logic                    aw_ready,
    input wb_types_pkg::addr_t     aw_addr,
    input wb_ctrl_pkg::len_t       aw_len,
    input logic                    w_valid,
    input logic                    w_ready,
    input wb_types_pkg::data_t     w_data,
    input logic                    w_last,
    input logic                    b_valid,
    input logic                    b_ready,
    input logic                    dma_ready
);
    import wb_ctrl_pkg::*;

    len_t burst_len;
    len_t beats_done;
    logic busy;

    // Beats accepted since the last address phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            burst_len  <= '0;
            beats_done <= '0;
        end else if (aw_valid && aw_ready) begin
            burst_len  <= aw_len;
            beats_done <= '0;
        end else if (w_valid && w_ready) begin
            beats_done <= beats_done + len_t'(1);
        end
    end

    // Address accepted and write response still outstanding
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            busy <= 1'b0;
        else if (b_valid && b_ready)
            busy <= 1'b0;
        else if (aw_valid && aw_ready)
            busy <= 1'b1;
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("AW channel changed before aw_ready");

    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
        else $error("W channel changed before w_ready");

    a_w_last: assert property (@(posedge clk) disable iff (!rstn)
        w_valid |-> (w_last == (beats_done == burst_len)))
        else $error("w_last not on the final beat of the burst");

    a_dma_idle: assert property (@(posedge clk) disable iff (!rstn)
        dma_ready |-> !busy && !aw_valid)
        else $error("dma_ready while a burst was in progress");

endmodule

bind write_fsm write_fsm_props u_props (
    .clk       (clk),
    .rstn      (rstn),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .aw_addr   (aw_addr),
    .aw_len    (aw_len),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w_data    (w_data),
    .w_last    (w_last),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .dma_ready (dma_ready)
);

`default_nettype wire

// ==== tests/tb_l2_write_back.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l2_write_back;
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    localparam int MAX_REC   = 32;
    localparam int REC_WORDS = 11; // kind, address, eight data words, group

    logic        clk;
    logic        rstn;
    logic        evict_valid, evict_ready, dma_valid, dma_ready;
    logic        aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    addr_t       evict_addr, dma_addr, aw_addr;
    data_t       evict_data, dma_data, w_data;
    len_t        aw_len;
    logic [31:0] vec_mem [MAX_REC*REC_WORDS];
    int          write_cnt [MAX_REC];
    int          n_rec, limit, last_group, next_line, seed;
    int          errors = 0;
    int          bursts = 0;
    int          done_cnt = 0;
    int          cycles = 0;
    int          cur_rec, cur_beat, cur_len, aw_stall, w_stall, b_stall;
    logic        burst_open = 1'b0;
    logic        b_pending = 1'b0;
    logic        dma_taken = 1'b0;
    logic        saw_stall = 1'b0;
    logic        aw_phase = 1'b0;
    logic        prev_dma_valid = 1'b0;
    addr_t       dma_taken_addr;
    addr_t       prev_dma_addr;

    clk_gen u_clk (.clk(clk), .rstn(rstn));

    l2_write_back #(.NUM_SLOTS(4)) DUT (.*);

    function automatic logic [31:0] rec_field(int rec, int col);
        return vec_mem[rec*REC_WORDS + col];
    endfunction

    function automatic int find_rec(addr_t a);
        for (int i = 0; i < n_rec; i++)
            if (rec_field(i, 1) == a)
                return i;
        return -1;
    endfunction

    // Next line record in file order or n_rec when none is left
    function automatic int line_after(int rec);
        for (int i = rec + 1; i < n_rec; i++)
            if (rec_field(i, 0) == 0)
                return i;
        return n_rec;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)", $time, what, got, exp);
        end
    endtask

    // Ready or valid pulses for one cycle after 0 to 3 idle cycles
    task automatic step_channel(input logic want, inout logic sig, inout int stall);
        if (sig) begin
            sig   = 1'b0;
            stall = $urandom % 4;
        end else if (want) begin
            if (stall == 0)
                sig = 1'b1;
            else
                stall--;
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(negedge clk);
            step_channel(aw_valid, aw_ready, aw_stall);
            step_channel(w_valid, w_ready, w_stall);
            step_channel(b_pending, b_valid, b_stall);
        end
    endtask

    task automatic send_line(input int rec);
        for (int b = 0; b < 8; b++) begin
            @(negedge clk);
            evict_valid = 1'b1;
            evict_addr  = rec_field(rec, 1);
            evict_data  = rec_field(rec, 2 + b);
            do @(posedge clk); while (!evict_ready);
        end
    endtask

    task automatic send_dma(input int rec);
        @(negedge clk);
        dma_valid = 1'b1;
        dma_addr  = rec_field(rec, 1);
        dma_data  = rec_field(rec, 2);
        do @(posedge clk); while (!dma_ready);
        @(negedge clk);
        dma_valid = 1'b0;
    endtask

    task automatic send_group(input int g);
        fork
            begin
                for (int i = 0; i < n_rec; i++)
                    if (rec_field(i, 0) == 0 && rec_field(i, 10) == g)
                        send_line(i);
                @(negedge clk);
                evict_valid = 1'b0;
            end
            begin
                repeat (12) @(negedge clk); // Lines get a head start
                for (int i = 0; i < n_rec; i++)
                    if (rec_field(i, 0) == 1 && rec_field(i, 10) == g)
                        send_dma(i);
            end
        join
    endtask

    task automatic monitor_memory();
        forever begin
            @(posedge clk);
            // An address phase opening right after a visible DMA request must carry it
            if (aw_valid && !aw_phase && prev_dma_valid)
                check_value(aw_addr, prev_dma_addr, "DMA request ahead of waiting lines");
            aw_phase       = aw_valid && !aw_ready;
            prev_dma_valid = dma_valid;
            prev_dma_addr  = dma_addr;
            if (evict_valid && !evict_ready)
                saw_stall = 1'b1;
            if (dma_valid && dma_ready) begin
                dma_taken      = 1'b1;
                dma_taken_addr = dma_addr;
            end
            if (aw_valid && aw_ready) begin
                if (burst_open) begin
                    errors++;
                    $display("New address phase at %0t ns before the write response", $time);
                end
                if (dma_taken)
                    check_value(aw_addr, dma_taken_addr, "first burst after dma_ready");
                dma_taken  = 1'b0;
                burst_open = 1'b1;
                bursts++;
                cur_beat = 0;
                cur_rec  = find_rec(aw_addr);
                if (cur_rec < 0) begin
                    errors++;
                    $display("Write to unknown address %h at %0t ns", aw_addr, $time);
                end else begin
                    write_cnt[cur_rec]++;
                    if (write_cnt[cur_rec] > 1) begin
                        errors++;
                        $display("Address %h written more than once", aw_addr);
                    end
                    cur_len = (rec_field(cur_rec, 0) == 0) ? 7 : 0;
                    check_value(32'(aw_len), 32'(cur_len), "aw_len");
                    if (cur_len == 7) begin
                        check_value(cur_rec, next_line, "line record in FIFO order");
                        next_line = line_after(cur_rec);
                    end
                end
            end
            if (w_valid && w_ready && cur_rec >= 0) begin
                if (cur_beat > cur_len) begin
                    errors++;
                    $display("Extra data beat to %h at %0t ns", aw_addr, $time);
                end else begin
                    check_value(w_data, rec_field(cur_rec, 2 + cur_beat),
                                $sformatf("w_data of %h beat %0d", rec_field(cur_rec, 1), cur_beat));
                    check_value(32'(w_last), 32'(cur_beat == cur_len), "w_last");
                end
                cur_beat++;
            end
            if (w_valid && w_ready && w_last)
                b_pending = 1'b1;
            if (b_valid && b_ready) begin
                if (cur_rec >= 0)
                    check_value(cur_beat, cur_len + 1, "data beats in burst");
                burst_open = 1'b0;
                b_pending  = 1'b0;
                done_cnt++;
            end
        end
    endtask

    task automatic watchdog();
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d records written", cycles, done_cnt, n_rec);
        $display("RESULT: FAIL");
        $finish;
    endtask

    initial begin
        int expected;

        seed        = $urandom(32'h8a8f_eb6d);
        evict_valid = 1'b0;
        evict_addr  = '0;
        evict_data  = '0;
        dma_valid   = 1'b0;
        dma_addr    = '0;
        dma_data    = '0;
        aw_ready    = 1'b0;
        w_ready     = 1'b0;
        b_valid     = 1'b0;
        aw_stall    = $urandom % 4;
        w_stall     = $urandom % 4;
        b_stall     = $urandom % 4;
        cur_rec     = -1;
        expected    = 0;

        for (int i = 0; i < MAX_REC*REC_WORDS; i++)
            vec_mem[i] = '1; // Kind all ones marks the end of the records
        $readmemh("tests/wb_vectors.txt", vec_mem);
        n_rec      = 0;
        last_group = 0;
        while (n_rec < MAX_REC && rec_field(n_rec, 0) < 2)
            n_rec++;
        for (int i = 0; i < MAX_REC; i++)
            write_cnt[i] = 0;
        for (int i = 0; i < n_rec; i++)
            if (rec_field(i, 10) > last_group)
                last_group = rec_field(i, 10);
        if (n_rec == 0) begin
            errors++;
            $display("No records read from tests/wb_vectors.txt");
        end
        next_line = line_after(-1);
        limit     = n_rec * (8 * 4 + 40) + 100;

        fork
            watchdog();
            drive_ready();
            monitor_memory();
        join_none

        @(posedge rstn);
        @(negedge clk);
        check_value(32'(aw_valid), 32'd0, "aw_valid after reset");
        check_value(32'(w_valid), 32'd0, "w_valid after reset");
        check_value(32'(b_ready), 32'd0, "b_ready after reset");
        check_value(32'(dma_ready), 32'd0, "dma_ready after reset");
        check_value(32'(evict_ready), 32'd1, "evict_ready after reset");

        for (int g = 0; g <= last_group; g++) begin
            send_group(g);
            for (int i = 0; i < n_rec; i++)
                if (rec_field(i, 10) == g)
                    expected++;
            while (done_cnt < expected)
                @(negedge clk);
        end

        for (int i = 0; i < n_rec; i++)
            if (write_cnt[i] == 0) begin
                errors++;
                $display("Record %0d at %h was never written", i, rec_field(i, 1));
            end
        check_value(bursts, n_rec, "total burst count");
        if (!saw_stall) begin
            errors++;
            $display("evict_ready never dropped while lines were offered");
        end

        $display("Finished with %0d errors over %0d bursts", errors, bursts);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/wb_vectors.txt ====
// kind (0 line, 1 DMA)  address  data0 .. data7  group
// A DMA record carries its word in data0, the other data columns are unused
0 00001000 1000a000 1000a111 1000a222 1000a333 1000a444 1000a555 1000a666 1000a777 0
1 00002004 5eed2004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
0 00003000 3000b000 3000b111 3000b222 3000b333 3000b444 3000b555 3000b666 3000b777 2
0 00003020 3020c000 3020c111 3020c222 3020c333 3020c444 3020c555 3020c666 3020c777 2
0 00003040 3040d000 3040d111 3040d222 3040d333 3040d444 3040d555 3040d666 3040d777 2
0 00003060 3060e000 3060e111 3060e222 3060e333 3060e444 3060e555 3060e666 3060e777 2
0 00003080 3080f000 3080f111 3080f222 3080f333 3080f444 3080f555 3080f666 3080f777 2
0 000030a0 30a09000 30a09111 30a09222 30a09333 30a09444 30a09555 30a09666 30a09777 2
0 00004000 40001000 40001111 40001222 40001333 40001444 40001555 40001666 40001777 3
0 00004020 40202000 40202111 40202222 40202333 40202444 40202555 40202666 40202777 3
0 00004040 40403000 40403111 40403222 40403333 40403444 40403555 40403666 40403777 3
1 00005008 0dd05008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3
0 00006000 60004000 60004111 60004222 60004333 60004444 60004555 60004666 60004777 4
1 00007000 77770000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4
0 00006020 60205000 60205111 60205222 60205333 60205444 60205555 60205666 60205777 4
1 0000700c 7777000c 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4

// ==== verilog.f ====
rtl/wb_types_pkg.sv
rtl/wb_ctrl_pkg.sv
rtl/wb_line_slot.sv
rtl/wb_fill.sv
rtl/write_fsm.sv
rtl/l2_write_back.sv
tests/clk_gen.sv
tests/write_fsm_props.sv
tests/tb_l2_write_back.sv

// ==== Makefile ====
TOP := tb_l2_write_back

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
